//--- source/memPkg.sv
package memPkg;

    ////////////////////////////////////////////////////////////////////////////
    // memory access widths and byte lanes
    ////////////////////////////////////////////////////////////////////////////

    localparam int wordBytes = 4;

    typedef logic [wordBytes-1:0] byteEnT;  // 0000 means no byte touched

    // load width and sign extension
    typedef enum logic [2:0] {
        loadLb,
        loadLbu,
        loadLh,
        loadLhu,
        loadLw
    } loadModeT;

    // one-hot store width
    typedef logic [2:0] storeModeT;
    localparam int storeSbBit = 0;
    localparam int storeShBit = 1;
    localparam int storeSwBit = 2;

    ////////////////////////////////////////////////////////////////////////////
    // exception codes raised by this stage
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [4:0] excCodeT;
    localparam excCodeT excNone  = 5'd0;
    localparam excCodeT excAdEL  = 5'd4;   // address error on load
    localparam excCodeT excAdES  = 5'd5;   // address error on store
    localparam excCodeT excOv    = 5'd12;  // integer overflow

endpackage

//--- source/exePkg.sv
package exePkg;

    localparam int wordWidth   = 32;
    localparam int gprNumWidth = 5;

    typedef logic [wordWidth-1:0]   wordT;
    typedef logic [gprNumWidth-1:0] gprNumT;  // zero means no write-back

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    // one-hot forwarding select, one bit per source
    localparam int fwdSources    = 5;
    localparam int fwdRegFileBit = 0;
    localparam int fwdExeUpBit   = 1;
    localparam int fwdExeDownBit = 2;
    localparam int fwdPreMemBit  = 3;
    localparam int fwdWbBit      = 4;  // the only unregistered source
    typedef logic [fwdSources-1:0] fwdSelT;

    // everything one instruction carries through the stage
    typedef struct packed {
        gprNumT              writeNum;
        aluOpT               aluOp;
        logic                ovfCheck;     // add/sub that traps on overflow
        wordT                oprand0;      // immediate or shift amount
        wordT                oprand1;
        logic                oprand0IsReg;
        logic                oprand1IsReg;
        wordT                regData0;     // register file read
        wordT                regData1;
        fwdSelT              fwdSel0;
        fwdSelT              fwdSel1;
        wordT                exeUpRes;
        wordT                exeDownRes;
        wordT                preMemRes;
        logic                memReq;
        logic                memWr;        // store when high
        memPkg::loadModeT    loadMode;
        memPkg::storeModeT   storeMode;
    } exeReqT;

endpackage

//--- source/exeOperandIf.sv
`timescale 1ns/10ps

// resolved operands, shared by the ALU and the memory access logic
interface exeOperandIf;
    import exePkg::*;

    wordT src0;      // ALU input 0
    wordT src1;      // ALU input 1
    wordT base;      // forwarded register 0, before the immediate mux
    wordT storeVal;  // forwarded register 1, data for stores

    modport fwd (output src0, output src1, output base, output storeVal);

    modport alu (input src0, input src1);

    modport mem (input base, input storeVal);

endinterface

//--- source/stageRegister.sv
`timescale 1ns/10ps

module stageRegister (
    input  logic           clk,
    input  logic           rst,
    input  logic           idValid_i,
    input  logic           memAllowin_i,
    input  logic           flush_i,
    input  exePkg::exeReqT req_i,
    output exePkg::exeReqT req_o,
    output logic           valid_o,
    output logic           allowin_o
);

    logic hasData;  // stage holds an instruction
    logic accept;

    // empty, or the content leaves this cycle
    assign allowin_o = !hasData || memAllowin_i;
    assign accept    = idValid_i && allowin_o;
    assign valid_o   = hasData;

    ////////////////////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst || flush_i) begin
            hasData <= 1'b0;  // flush wins over a new arrival
        end else if (allowin_o) begin
            hasData <= idValid_i;  // refill, or drain when nothing comes
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            req_o <= req_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    flushEmpties: assert property (@(posedge clk) disable iff (!rst)
        flush_i |=> !valid_o)
        else $error("stage still valid after flush");

endmodule

//--- source/operandForward.sv
`timescale 1ns/10ps

module operandForward (
    input  exePkg::exeReqT req_i,
    input  exePkg::wordT   wbData_i,
    exeOperandIf.fwd       ops
);
    import exePkg::*;

    wordT fwdVal0;
    wordT fwdVal1;

    // and-or mux over the one-hot select
    function automatic wordT pickSource(fwdSelT sel, wordT regData, wordT upRes,
                                        wordT downRes, wordT preMemRes, wordT wbRes);
        return ({wordWidth{sel[fwdRegFileBit]}} & regData)   |
               ({wordWidth{sel[fwdExeUpBit]}}   & upRes)     |
               ({wordWidth{sel[fwdExeDownBit]}} & downRes)   |
               ({wordWidth{sel[fwdPreMemBit]}}  & preMemRes) |
               ({wordWidth{sel[fwdWbBit]}}      & wbRes);
    endfunction

    assign fwdVal0 = pickSource(req_i.fwdSel0, req_i.regData0, req_i.exeUpRes,
                                req_i.exeDownRes, req_i.preMemRes, wbData_i);
    assign fwdVal1 = pickSource(req_i.fwdSel1, req_i.regData1, req_i.exeUpRes,
                                req_i.exeDownRes, req_i.preMemRes, wbData_i);

    assign ops.src0     = req_i.oprand0IsReg ? fwdVal0 : req_i.oprand0;
    assign ops.src1     = req_i.oprand1IsReg ? fwdVal1 : req_i.oprand1;
    assign ops.base     = fwdVal0;  // address base even when src0 is an sa
    assign ops.storeVal = fwdVal1;

    // decode must name exactly one source for a register operand
    always_comb begin
        if (req_i.oprand0IsReg) begin
            assert ($onehot(req_i.fwdSel0)) else $error("fwdSel0 not one-hot");
        end
        if (req_i.oprand1IsReg) begin
            assert ($onehot(req_i.fwdSel1)) else $error("fwdSel1 not one-hot");
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/10ps

module alu (
    input  exePkg::aluOpT aluOp_i,
    exeOperandIf.alu      ops,
    output exePkg::wordT  aluRes_o,
    output logic          overflow_o
);
    import exePkg::*;

    wordT       sum;
    wordT       diff;
    logic [4:0] shamt;
    logic       sumOvf;
    logic       diffOvf;

    assign sum   = ops.src0 + ops.src1;
    assign diff  = ops.src0 - ops.src1;
    assign shamt = ops.src0[4:0];  // shifts take the amount from src0

    // same-sign inputs, result sign flipped
    assign sumOvf  = (ops.src0[wordWidth-1] == ops.src1[wordWidth-1]) &&
                     (sum[wordWidth-1] != ops.src0[wordWidth-1]);
    // opposite signs, result takes the subtrahend's sign
    assign diffOvf = (ops.src0[wordWidth-1] != ops.src1[wordWidth-1]) &&
                     (diff[wordWidth-1] != ops.src0[wordWidth-1]);

    always_comb begin
        case (aluOp_i)
            aluAdd:  aluRes_o = sum;
            aluSub:  aluRes_o = diff;
            aluAnd:  aluRes_o = ops.src0 & ops.src1;
            aluOr:   aluRes_o = ops.src0 | ops.src1;
            aluXor:  aluRes_o = ops.src0 ^ ops.src1;
            aluNor:  aluRes_o = ~(ops.src0 | ops.src1);
            aluSlt:  aluRes_o = {{(wordWidth-1){1'b0}}, $signed(ops.src0) < $signed(ops.src1)};
            aluSltu: aluRes_o = {{(wordWidth-1){1'b0}}, ops.src0 < ops.src1};
            aluSll:  aluRes_o = ops.src1 << shamt;
            aluSrl:  aluRes_o = ops.src1 >> shamt;
            aluSra:  aluRes_o = $signed(ops.src1) >>> shamt;
            aluLui:  aluRes_o = {ops.src1[15:0], 16'h0000};
            default: aluRes_o = '0;
        endcase
    end

    // only add and sub can overflow
    assign overflow_o = (aluOp_i == aluAdd) ? sumOvf  :
                        (aluOp_i == aluSub) ? diffOvf : 1'b0;

endmodule

//--- source/memAccess.sv
`timescale 1ns/10ps

module memAccess (
    input  exePkg::exeReqT   req_i,
    input  logic             valid_i,
    exeOperandIf.mem         ops,
    input  exePkg::wordT     aluRes_i,
    input  logic             overflow_i,
    output memPkg::byteEnT   memEnable_o,
    output exePkg::wordT     storeData_o,
    output logic             hasException_o,
    output memPkg::excCodeT  excCode_o
);
    import memPkg::*;

    logic [1:0] offset;   // byte within the word
    byteEnT     storeEn;
    logic       halfMis;
    logic       wordMis;
    logic       loadMis;
    logic       storeMis;

    assign offset = aluRes_i[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // byte lanes and store data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        storeEn = '1;  // sw
        if (req_i.storeMode[storeSbBit]) begin
            storeEn = byteEnT'(1) << offset;
        end else if (req_i.storeMode[storeShBit]) begin
            storeEn = (offset == 2'd0) ? 4'b0011 :
                      (offset == 2'd2) ? 4'b1100 : 4'b0000;  // odd halfword
        end
    end

    assign memEnable_o = req_i.memWr ? storeEn : '1;  // loads read the full word

    // replicate so the lane picked by the enables carries the data
    always_comb begin
        storeData_o = ops.storeVal;
        if (req_i.storeMode[storeSbBit]) begin
            storeData_o = {wordBytes{ops.storeVal[7:0]}};
        end else if (req_i.storeMode[storeShBit]) begin
            storeData_o = {2{ops.storeVal[15:0]}};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // exceptions
    ////////////////////////////////////////////////////////////////////////////

    assign halfMis = offset[0];
    assign wordMis = |offset;

    assign loadMis  = req_i.memReq && !req_i.memWr &&
                      ((((req_i.loadMode == loadLh) || (req_i.loadMode == loadLhu)) && halfMis) ||
                       ((req_i.loadMode == loadLw) && wordMis));
    assign storeMis = req_i.memReq && req_i.memWr &&
                      ((req_i.storeMode[storeShBit] && halfMis) ||
                       (req_i.storeMode[storeSwBit] && wordMis));

    always_comb begin
        hasException_o = 1'b0;
        excCode_o      = excNone;
        if (valid_i) begin
            if (req_i.ovfCheck && overflow_i) begin  // overflow first
                hasException_o = 1'b1;
                excCode_o      = excOv;
            end else if (loadMis) begin
                hasException_o = 1'b1;
                excCode_o      = excAdEL;
            end else if (storeMis) begin
                hasException_o = 1'b1;
                excCode_o      = excAdES;
            end
        end
    end

    always_comb begin
        if (valid_i && req_i.memReq && req_i.memWr) begin
            assert ($onehot(req_i.storeMode)) else $error("storeMode not one-hot");
        end
    end

endmodule

//--- source/exeDown.sv
`timescale 1ns/10ps

module exeDown (
    input  logic               clk,
    input  logic               rst,
    input  logic               idValid_i,
    input  logic               memAllowin_i,
    input  logic               flush_i,
    input  exePkg::gprNumT     writeNum_i,
    input  exePkg::aluOpT      aluOp_i,
    input  logic               ovfCheck_i,
    input  exePkg::wordT       oprand0_i,
    input  exePkg::wordT       oprand1_i,
    input  logic               oprand0IsReg_i,
    input  logic               oprand1IsReg_i,
    input  exePkg::wordT       regData0_i,
    input  exePkg::wordT       regData1_i,
    input  exePkg::fwdSelT     fwdSel0_i,
    input  exePkg::fwdSelT     fwdSel1_i,
    input  exePkg::wordT       exeUpRes_i,
    input  exePkg::wordT       exeDownRes_i,
    input  exePkg::wordT       preMemRes_i,
    input  exePkg::wordT       wbData_i,
    input  logic               memReq_i,
    input  logic               memWr_i,
    input  memPkg::loadModeT   loadMode_i,
    input  memPkg::storeModeT  storeMode_i,
    output logic               exeAllowin_o,
    output logic               exeValid_o,
    output exePkg::gprNumT     writeNum_o,
    output exePkg::wordT       aluRes_o,
    output exePkg::wordT       badVAddr_o,
    output logic               hasException_o,
    output memPkg::excCodeT    excCode_o,
    output logic               memReq_o,
    output logic               memWr_o,
    output memPkg::byteEnT     memEnable_o,
    output exePkg::wordT       storeData_o
);
    import exePkg::*;

    exeReqT idReq;   // decode side, not yet registered
    exeReqT exeReq;  // held instruction
    logic   exeValid;
    wordT   aluRes;
    logic   overflow;

    exeOperandIf ops ();

    assign idReq.writeNum     = writeNum_i;
    assign idReq.aluOp        = aluOp_i;
    assign idReq.ovfCheck     = ovfCheck_i;
    assign idReq.oprand0      = oprand0_i;
    assign idReq.oprand1      = oprand1_i;
    assign idReq.oprand0IsReg = oprand0IsReg_i;
    assign idReq.oprand1IsReg = oprand1IsReg_i;
    assign idReq.regData0     = regData0_i;
    assign idReq.regData1     = regData1_i;
    assign idReq.fwdSel0      = fwdSel0_i;
    assign idReq.fwdSel1      = fwdSel1_i;
    assign idReq.exeUpRes     = exeUpRes_i;
    assign idReq.exeDownRes   = exeDownRes_i;
    assign idReq.preMemRes    = preMemRes_i;
    assign idReq.memReq       = memReq_i;
    assign idReq.memWr        = memWr_i;
    assign idReq.loadMode     = loadMode_i;
    assign idReq.storeMode    = storeMode_i;

    stageRegister stageRegister_i (
        .clk          (clk),
        .rst          (rst),
        .idValid_i    (idValid_i),
        .memAllowin_i (memAllowin_i),
        .flush_i      (flush_i),
        .req_i        (idReq),
        .req_o        (exeReq),
        .valid_o      (exeValid),
        .allowin_o    (exeAllowin_o)
    );

    operandForward operandForward_i (
        .req_i    (exeReq),
        .wbData_i (wbData_i),  // live, not registered
        .ops      (ops)
    );

    alu alu_i (
        .aluOp_i    (exeReq.aluOp),
        .ops        (ops),
        .aluRes_o   (aluRes),
        .overflow_o (overflow)
    );

    memAccess memAccess_i (
        .req_i          (exeReq),
        .valid_i        (exeValid),
        .ops            (ops),
        .aluRes_i       (aluRes),
        .overflow_i     (overflow),
        .memEnable_o    (memEnable_o),
        .storeData_o    (storeData_o),
        .hasException_o (hasException_o),
        .excCode_o      (excCode_o)
    );

    assign exeValid_o = exeValid;
    assign writeNum_o = exeReq.writeNum;
    assign aluRes_o   = aluRes;
    assign badVAddr_o = aluRes;  // faulting address is the computed one
    assign memReq_o   = exeReq.memReq;
    assign memWr_o    = exeReq.memWr;

endmodule

//--- bench/exeDownTb.sv
`timescale 1ns/10ps

module exeDownTb;
    import exePkg::*;
    import memPkg::*;

    typedef struct packed {
        gprNumT  writeNum;
        wordT    aluRes;
        logic    hasExc;
        excCodeT excCode;
        logic    memReq;
        logic    memWr;
        byteEnT  memEnable;
        wordT    storeData;
    } expT;

    logic      clk = 0, rst = 0, idValid = 0, memAllowin = 1, flush = 0;
    gprNumT    writeNum;
    aluOpT     aluOp;
    logic      ovfCheck, opr0IsReg, opr1IsReg, memReq, memWr;
    wordT      opr0, opr1, regData0, regData1, exeUpRes, exeDownRes, preMemRes, wbData;
    fwdSelT    fwdSel0, fwdSel1;
    loadModeT  loadMode;
    storeModeT storeMode;
    logic      exeAllowin_o, exeValid_o, hasException_o, memReq_o, memWr_o;
    gprNumT    writeNum_o;
    wordT      aluRes_o, badVAddr_o, storeData_o;
    excCodeT   excCode_o;
    byteEnT    memEnable_o;

    expT expQ[$];
    expT expHead;
    logic headValid = 0, takeNow = 0, acceptNow = 0, flushNow = 0, stallMode = 0;
    logic [31:0] lfsr = 32'h70ea_6b4c;
    string testName = "reset";
    int errors = 0, testsRun = 0, testsFailed = 0, errAtStart = 0;

    exeDown dut_i (.clk(clk), .rst(rst), .idValid_i(idValid), .memAllowin_i(memAllowin),
        .flush_i(flush), .writeNum_i(writeNum), .aluOp_i(aluOp), .ovfCheck_i(ovfCheck),
        .oprand0_i(opr0), .oprand1_i(opr1), .oprand0IsReg_i(opr0IsReg),
        .oprand1IsReg_i(opr1IsReg), .regData0_i(regData0), .regData1_i(regData1),
        .fwdSel0_i(fwdSel0), .fwdSel1_i(fwdSel1), .exeUpRes_i(exeUpRes),
        .exeDownRes_i(exeDownRes), .preMemRes_i(preMemRes), .wbData_i(wbData),
        .memReq_i(memReq), .memWr_i(memWr), .loadMode_i(loadMode), .storeMode_i(storeMode),
        .exeAllowin_o(exeAllowin_o), .exeValid_o(exeValid_o), .writeNum_o(writeNum_o),
        .aluRes_o(aluRes_o), .badVAddr_o(badVAddr_o), .hasException_o(hasException_o),
        .excCode_o(excCode_o), .memReq_o(memReq_o), .memWr_o(memWr_o),
        .memEnable_o(memEnable_o), .storeData_o(storeData_o));

    always #5 clk = !clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrBits(int n);
        logic [31:0] r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic wordT pickFwd(fwdSelT sel, wordT regData);
        case (sel)
            5'b00001: return regData;
            5'b00010: return exeUpRes;
            5'b00100: return exeDownRes;
            5'b01000: return preMemRes;
            5'b10000: return wbData;
            default:  return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic expT refModel();
        expT e;
        wordT a, b, sv;
        longint wide;
        e = '0;
        a = opr0IsReg ? pickFwd(fwdSel0, regData0) : opr0;
        b = opr1IsReg ? pickFwd(fwdSel1, regData1) : opr1;
        sv = pickFwd(fwdSel1, regData1);
        wide = (aluOp == aluSub) ? longint'($signed(a)) - longint'($signed(b))
                                 : longint'($signed(a)) + longint'($signed(b));
        case (aluOp)
            aluAdd:  e.aluRes = a + b;
            aluSub:  e.aluRes = a - b;
            aluAnd:  e.aluRes = a & b;
            aluOr:   e.aluRes = a | b;
            aluXor:  e.aluRes = a ^ b;
            aluNor:  e.aluRes = ~(a | b);
            aluSlt:  e.aluRes = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: e.aluRes = (a < b) ? 32'd1 : 32'd0;
            aluSll:  e.aluRes = b << a[4:0];
            aluSrl:  e.aluRes = b >> a[4:0];
            aluSra:  e.aluRes = $signed(b) >>> a[4:0];
            default: e.aluRes = {b[15:0], 16'h0};
        endcase
        e.writeNum = writeNum;
        e.memReq = memReq;
        e.memWr = memWr;
        e.memEnable = 4'b1111;  // loads and sw
        e.storeData = sv;
        if (storeMode == 3'b001) begin
            e.memEnable = 4'b0001 << e.aluRes[1:0];
            e.storeData = {4{sv[7:0]}};
        end else if (storeMode == 3'b010) begin
            e.memEnable = (e.aluRes[1:0] == 0) ? 4'b0011 :
                          (e.aluRes[1:0] == 2) ? 4'b1100 : 4'b0;
            e.storeData = {2{sv[15:0]}};
        end
        if (!memWr) e.memEnable = 4'b1111;
        if (ovfCheck && (aluOp == aluAdd || aluOp == aluSub) &&
            (wide > 64'sh7fff_ffff || wide < -64'sh8000_0000)) begin
            e.hasExc = 1;
            e.excCode = 5'd12;
        end else if (memReq && !memWr && ((loadMode == loadLw && e.aluRes[1:0] != 0) ||
                ((loadMode == loadLh || loadMode == loadLhu) && e.aluRes[0]))) begin
            e.hasExc = 1;
            e.excCode = 5'd4;
        end else if (memReq && memWr && ((storeMode == 3'b100 && e.aluRes[1:0] != 0) ||
                (storeMode == 3'b010 && e.aluRes[0]))) begin
            e.hasExc = 1;
            e.excCode = 5'd5;
        end
        return e;
    endfunction

    // handshake decisions settle well before the next rising edge
    always @(negedge clk) begin
        #2;
        takeNow = rst && exeValid_o && memAllowin;
        acceptNow = rst && idValid && exeAllowin_o;
        flushNow = rst && flush;
    end

    always @(posedge clk) begin
        if (takeNow && expQ.size() > 0) void'(expQ.pop_front());
        if (flushNow) expQ.delete();
        else if (acceptNow) expQ.push_back(refModel());
        headValid = expQ.size() > 0;
        if (headValid) expHead = expQ[0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    logic take;
    assign take = exeValid_o && memAllowin;

    chkHead: assert property (@(posedge clk) disable iff (!rst) take |-> headValid)
        else begin
            errors++;
            $display("[FAIL] %s: output without accepted instruction", testName);
        end
    chkRes: assert property (@(posedge clk) disable iff (!rst)
        take |-> aluRes_o == expHead.aluRes && badVAddr_o == expHead.aluRes)
        else begin
            errors++;
            $display("[FAIL] %s aluRes/badVAddr expected %h actual %h/%h", testName,
                     $sampled(expHead.aluRes), $sampled(aluRes_o), $sampled(badVAddr_o));
        end
    chkExc: assert property (@(posedge clk) disable iff (!rst)
        take |-> {hasException_o, excCode_o} == {expHead.hasExc, expHead.excCode})
        else begin
            errors++;
            $display("[FAIL] %s exception expected %b/%0d actual %b/%0d", testName,
                     $sampled(expHead.hasExc), $sampled(expHead.excCode),
                     $sampled(hasException_o), $sampled(excCode_o));
        end
    chkMem: assert property (@(posedge clk) disable iff (!rst) take && expHead.memReq |->
        memEnable_o == expHead.memEnable && (!memWr_o || storeData_o == expHead.storeData))
        else begin
            errors++;
            $display("[FAIL] %s enable/data expected %b/%h actual %b/%h", testName,
                     $sampled(expHead.memEnable), $sampled(expHead.storeData),
                     $sampled(memEnable_o), $sampled(storeData_o));
        end
    chkCtl: assert property (@(posedge clk) disable iff (!rst) take |->
        {writeNum_o, memReq_o, memWr_o} == {expHead.writeNum, expHead.memReq, expHead.memWr})
        else begin
            errors++;
            $display("[FAIL] %s control expected %h actual %h", testName,
                     $sampled({expHead.writeNum, expHead.memReq, expHead.memWr}),
                     $sampled({writeNum_o, memReq_o, memWr_o}));
        end
    chkLatency: assert property (@(posedge clk) disable iff (!rst)
        acceptNow && !flushNow |=> exeValid_o)
        else begin
            errors++;
            $display("[FAIL] %s: exeValid_o missing after acceptance", testName);
        end
    chkStall: assert property (@(posedge clk) disable iff (!rst)
        exeValid_o && !memAllowin && !flush |=> exeValid_o &&
        $stable({aluRes_o, badVAddr_o, hasException_o, excCode_o, memReq_o, memWr_o,
                 memEnable_o, storeData_o, writeNum_o}))
        else begin
            errors++;
            $display("[FAIL] %s: outputs moved under back-pressure", testName);
        end
    chkAllowin: assert property (@(posedge clk) disable iff (!rst)
        exeValid_o && !memAllowin |-> !exeAllowin_o)
        else begin
            errors++;
            $display("[FAIL] %s: exeAllowin_o high while stalled", testName);
        end
    chkFlush: assert property (@(posedge clk) disable iff (!rst) flush |=> !exeValid_o)
        else begin
            errors++;
            $display("[FAIL] %s: exeValid_o high after flush", testName);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic plainInstr(aluOpT op, wordT a, wordT b, logic ovf);
        aluOp = op;
        opr0 = a;
        opr1 = b;
        ovfCheck = ovf;
        writeNum = gprNumT'(lfsrBits(5));
        opr0IsReg = 0;
        opr1IsReg = 0;
        fwdSel0 = 5'b00001;
        fwdSel1 = 5'b00001;
        memReq = 0;
        memWr = 0;
        loadMode = loadLw;
        storeMode = 3'b100;
    endtask

    task automatic sendOne();
        int waitCnt = 0;
        idValid = 1;
        #1;
        while (!exeAllowin_o && waitCnt < 100) begin
            @(negedge clk);
            if (stallMode) memAllowin = lfsrBits(1) != 0;
            #1;
            waitCnt++;
        end
        if (!exeAllowin_o) begin
            errors++;
            $display("%s: timed out waiting for exeAllowin_o", testName);
        end
        @(negedge clk);
        idValid = 0;
        if (stallMode) memAllowin = lfsrBits(1) != 0;
    endtask

    task automatic drain();
        int waitCnt = 0;
        while ((expQ.size() > 0 || exeValid_o) && waitCnt < 200) begin
            memAllowin = stallMode ? lfsrBits(1) != 0 : 1'b1;
            @(negedge clk);
            waitCnt++;
        end
        memAllowin = 1;
        if (expQ.size() > 0) begin
            errors++;
            $display("%s: timed out draining, %0d instructions lost", testName, expQ.size());
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        errAtStart = errors;
    endtask

    task automatic endTest();
        drain();
        testsRun++;
        if (errors != errAtStart) testsFailed++;
        $display("test %s: %0d errors", testName, errors - errAtStart);
    endtask

    initial begin
        plainInstr(aluAdd, 0, 0, 0);
        {regData0, regData1, exeUpRes, exeDownRes, preMemRes, wbData} = '0;
        repeat (10) @(negedge clk);
        rst = 1;
        startTest("randomAlu");
        for (int i = 0; i < 48; i++) begin
            plainInstr(aluOpT'(4'(i % 12)), lfsrBits(32), lfsrBits(32), 0);
            sendOne();
        end
        endTest();
        startTest("overflow");
        for (int c = 0; c < 2; c++) begin
            plainInstr(aluAdd, 32'h7fff_ffff, 32'd1, c == 0);
            sendOne();
            plainInstr(aluAdd, 32'h8000_0000, 32'hffff_ffff, c == 0);
            sendOne();
            plainInstr(aluSub, 32'h8000_0000, 32'd1, c == 0);
            sendOne();
            plainInstr(aluSub, 32'h7fff_ffff, 32'hffff_ffff, c == 0);
            sendOne();
        end
        endTest();
        startTest("forwarding");
        {regData0, exeUpRes, exeDownRes, preMemRes} = {lfsrBits(32), lfsrBits(32),
            lfsrBits(32), lfsrBits(32)};
        wbData = lfsrBits(32);
        for (int s = 0; s < 5; s++) begin
            plainInstr(aluAdd, 0, 0, 0);
            opr0IsReg = 1;
            fwdSel0 = fwdSelT'(1 << s);
            sendOne();
        end
        // the wb add is still held, a new wb value must reach aluRes_o
        wbData = lfsrBits(32);
        expQ[0].aluRes = wbData;
        expHead.aluRes = wbData;
        endTest();
        startTest("memory");
        for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 8; k++) begin
                plainInstr(aluAdd, 0, wordT'(off), 0);
                opr0IsReg = 1;
                regData0 = 32'h0000_1000;
                regData1 = lfsrBits(32);
                memReq = 1;
                memWr = k < 3;
                storeMode = storeModeT'(1 << (k % 3));
                loadMode = loadModeT'(3'(k % 5));
                sendOne();
            end
        end
        endTest();
        startTest("backPressure");
        stallMode = 1;
        for (int i = 0; i < 40; i++) begin
            plainInstr(aluOpT'(4'(lfsrBits(4) % 12)), lfsrBits(32), lfsrBits(32),
                       lfsrBits(1) != 0);
            sendOne();
        end
        endTest();
        stallMode = 0;
        startTest("flush");
        plainInstr(aluXor, 32'h1234_5678, 32'hffff_0000, 0);
        sendOne();
        memAllowin = 0;
        @(negedge clk);
        flush = 1;
        plainInstr(aluOr, 32'h0f0f_0f0f, 32'h0000_ffff, 0);
        idValid = 1;  // offered on the flush edge, must be dropped
        @(negedge clk);
        // empty stage with allowin high still refuses the or while flush is high
        @(negedge clk);
        flush = 0;
        idValid = 0;
        memAllowin = 1;
        plainInstr(aluNor, 32'h5555_0000, 32'h0000_aaaa, 0);
        sendOne();
        endTest();
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
source/memPkg.sv
source/exePkg.sv
source/exeOperandIf.sv
source/stageRegister.sv
source/operandForward.sv
source/alu.sv
source/memAccess.sv
source/exeDown.sv
bench/exeDownTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the exeDown testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module exeDownTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/VexeDownTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
